/* parser_pkg.sv */
`default_nettype none

package parser_pkg;

	// ========================================================================
	// widths and field offsets
	// ========================================================================
	localparam int DATA_W      = 512;
	localparam int KEEP_W      = DATA_W / 8;
	localparam int TUSER_W     = 128;
	localparam int VLAN_W      = 12;
	localparam int NUM_QUEUES  = 4;
	localparam int QSEL_W      = $clog2(NUM_QUEUES);
	localparam int TBL_DEPTH   = 32;
	localparam int TBL_AW      = $clog2(TBL_DEPTH);
	localparam int ENTRY_BYTES = 20;
	localparam int ENTRY_W     = ENTRY_BYTES * 8;

	localparam logic [2:0]  PARSER_MOD_ID = 3'd0;
	localparam logic [15:0] CTRL_FLAG_WR  = 16'hf2f1;

	// bit offsets inside a control-stream tdata word
	localparam int MOD_ID_LSB    = 368;
	localparam int CTRL_FLAG_LSB = 320;
	localparam int TBL_INDEX_LSB = 384;

	// table address starts here in the vlan id
	localparam int VLAN_ADDR_LSB = 4;

	// ========================================================================
	// types
	// ========================================================================
	typedef logic [DATA_W-1:0]     data_w_t;
	typedef logic [KEEP_W-1:0]     keep_t;
	typedef logic [TUSER_W-1:0]    tuser_t;
	typedef logic [VLAN_W-1:0]     vlan_id_t;
	typedef logic [ENTRY_W-1:0]    act_entry_t;
	typedef logic [TBL_AW-1:0]     tbl_addr_t;
	typedef logic [QSEL_W-1:0]     queue_sel_t;
	typedef logic [NUM_QUEUES-1:0] queue_mask_t;

	typedef struct packed {
		data_w_t tdata;
		keep_t   tkeep;
		tuser_t  tuser;
		logic    tlast;
	} axis_beat_t;

	typedef struct packed {
		queue_mask_t tag;
		act_entry_t  entry;
	} action_result_t;

	typedef struct packed {
		logic       wr_en;
		tbl_addr_t  addr;
		act_entry_t data;
	} tbl_wr_t;

	typedef enum logic {
		DISP_IDLE,
		DISP_FLUSH
	} dispatch_state_t;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_WRITE,
		CTRL_NEXT_WRITE
	} ctrl_state_t;

	typedef enum logic {
		LKUP_IDLE,
		LKUP_READ
	} lookup_state_t;

	// queue number to one-hot mask
	function automatic queue_mask_t queue_onehot(input queue_sel_t sel);
		queue_mask_t mask;
		mask = '0;
		mask[sel] = 1'b1;
		return mask;
	endfunction

endpackage

`default_nettype wire

/* pkt_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_dispatch (
	input  wire                     axis_clk,
	input  wire                     aresetn,
	input  wire                     s_axis_tvalid,
	input  wire                     s_axis_tlast,
	input  wire parser_pkg::queue_mask_t m_axis_tready,
	output parser_pkg::queue_mask_t m_axis_tvalid
);
	import parser_pkg::*;

	dispatch_state_t state_q;
	dispatch_state_t state_d;
	queue_sel_t      cur_queue_q;
	queue_sel_t      cur_queue_d;
	logic            xfer;

	// valid goes to the current queue only
	assign m_axis_tvalid = s_axis_tvalid ? queue_onehot(cur_queue_q) : '0;

	// a beat moves only when the selected queue takes it
	assign xfer = s_axis_tvalid && m_axis_tready[cur_queue_q];

	// ========================================================================
	// packet boundary tracking
	// ========================================================================
	always_comb begin
		state_d     = state_q;
		cur_queue_d = cur_queue_q;

		case (state_q)
			DISP_IDLE: begin
				if (xfer) begin
					if (s_axis_tlast) begin
						// single-beat packet
						cur_queue_d = cur_queue_q + 1'b1;
					end else begin
						state_d = DISP_FLUSH;
					end
				end
			end
			DISP_FLUSH: begin
				// rest of the packet stays on this queue
				if (xfer && s_axis_tlast) begin
					cur_queue_d = cur_queue_q + 1'b1;
					state_d     = DISP_IDLE;
				end
			end
			default: begin
				state_d = DISP_IDLE;
			end
		endcase
	end

	// pointer wraps 3 -> 0 by width
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			state_q     <= DISP_IDLE;
			cur_queue_q <= '0;
		end else begin
			state_q     <= state_d;
			cur_queue_q <= cur_queue_d;
		end
	end

endmodule

`default_nettype wire

/* ctrl_entry_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_entry_writer (
	input  wire                         axis_clk,
	input  wire                         aresetn,
	input  wire parser_pkg::axis_beat_t ctrl_s_axis,
	input  wire                         ctrl_s_axis_tvalid,
	output parser_pkg::axis_beat_t      ctrl_m_axis,
	output logic                        ctrl_m_axis_tvalid,
	output parser_pkg::tbl_wr_t         tbl_wr
);
	import parser_pkg::*;

	ctrl_state_t state_q;
	logic [2:0]  mod_id;
	logic [15:0] ctrl_flag;
	logic        is_cfg_hdr;
	act_entry_t  entry_swapped;
	logic        wr_en_q;
	tbl_addr_t   wr_addr_q;
	act_entry_t  wr_data_q;

	// ========================================================================
	// header decode
	// ========================================================================
	assign mod_id     = ctrl_s_axis.tdata[MOD_ID_LSB +: 3];
	assign ctrl_flag  = ctrl_s_axis.tdata[CTRL_FLAG_LSB +: 16];
	assign is_cfg_hdr = ctrl_s_axis_tvalid && (mod_id == PARSER_MOD_ID)
		&& (ctrl_flag == CTRL_FLAG_WR);

	// byte 0 of the beat lands in the top byte of the entry
	always_comb begin
		entry_swapped = '0;
		for (int i = 0; i < ENTRY_BYTES; i++) begin
			entry_swapped[(ENTRY_BYTES-1-i)*8 +: 8] = ctrl_s_axis.tdata[i*8 +: 8];
		end
	end

	assign tbl_wr = '{wr_en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

	// ========================================================================
	// control FSM
	// ========================================================================
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			state_q            <= CTRL_IDLE;
			ctrl_m_axis_tvalid <= 1'b0;
			wr_en_q            <= 1'b0;
		end else begin
			case (state_q)
				CTRL_IDLE: begin
					wr_en_q            <= 1'b0;
					// config packets are swallowed here
					ctrl_m_axis_tvalid <= ctrl_s_axis_tvalid && !is_cfg_hdr;
					if (is_cfg_hdr) begin
						state_q <= CTRL_WRITE;
					end
				end
				CTRL_WRITE, CTRL_NEXT_WRITE: begin
					ctrl_m_axis_tvalid <= 1'b0;
					wr_en_q            <= ctrl_s_axis_tvalid;
					if (ctrl_s_axis_tvalid) begin
						state_q <= ctrl_s_axis.tlast ? CTRL_IDLE : CTRL_NEXT_WRITE;
					end
				end
				default: begin
					state_q <= CTRL_IDLE;
				end
			endcase
		end
	end

	// pass-through beat and write payload
	always_ff @(posedge axis_clk) begin
		case (state_q)
			CTRL_IDLE: begin
				if (is_cfg_hdr) begin
					// first write goes to the header index
					wr_addr_q <= ctrl_s_axis.tdata[TBL_INDEX_LSB +: TBL_AW];
				end else begin
					ctrl_m_axis <= ctrl_s_axis;
				end
			end
			CTRL_WRITE: begin
				if (ctrl_s_axis_tvalid) begin
					wr_data_q <= entry_swapped;
				end
			end
			CTRL_NEXT_WRITE: begin
				if (ctrl_s_axis_tvalid) begin
					wr_addr_q <= wr_addr_q + 1'b1;
					wr_data_q <= entry_swapped;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* parse_action_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module parse_action_ram (
	input  wire                          axis_clk,
	input  wire parser_pkg::tbl_wr_t     tbl_wr,
	input  wire parser_pkg::tbl_addr_t   rd_addr,
	output parser_pkg::act_entry_t       rd_data
);
	import parser_pkg::*;

	// ========================================================================
	// simple dual-port table, one write and one registered read
	// ========================================================================
	act_entry_t mem [TBL_DEPTH];

	always_ff @(posedge axis_clk) begin
		if (tbl_wr.wr_en) begin
			mem[tbl_wr.addr] <= tbl_wr.data;
		end
	end

	// read-first on an address collision
	always_ff @(posedge axis_clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* action_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module action_lookup (
	input  wire                          axis_clk,
	input  wire                          aresetn,
	input  wire parser_pkg::vlan_id_t    s_vlan_id,
	input  wire                          s_vlan_id_valid,
	input  wire                          s_axis_tvalid,
	input  wire                          s_axis_tlast,
	input  wire parser_pkg::act_entry_t  rd_data,
	output parser_pkg::tbl_addr_t        rd_addr,
	output logic                         s_axis_tready,
	output parser_pkg::action_result_t   act_result,
	output logic                         act_valid
);
	import parser_pkg::*;

	lookup_state_t state_q;
	logic          accept;
	logic          data_pend_q;
	act_entry_t    entry_q;
	queue_sel_t    tag_ptr_q;

	// RAM samples this on every edge
	assign rd_addr = s_vlan_id[VLAN_ADDR_LSB +: TBL_AW];
	assign accept  = (state_q == LKUP_IDLE) && s_vlan_id_valid;

	// ========================================================================
	// lookup sequencer
	// ========================================================================
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			state_q       <= LKUP_IDLE;
			data_pend_q   <= 1'b0;
			act_valid     <= 1'b0;
			s_axis_tready <= 1'b1;
			tag_ptr_q     <= '0;
		end else begin
			// RAM data is valid one cycle after acceptance
			data_pend_q <= (state_q == LKUP_READ);
			act_valid   <= data_pend_q;
			if (data_pend_q) begin
				tag_ptr_q <= tag_ptr_q + 1'b1;
			end

			case (state_q)
				LKUP_IDLE: begin
					if (accept) begin
						state_q <= LKUP_READ;
						// hold the source off when a packet ends on this cycle
						if (s_axis_tvalid && s_axis_tlast) begin
							s_axis_tready <= 1'b0;
						end
					end
				end
				LKUP_READ: begin
					// busy cycle, a new valid is ignored
					state_q       <= LKUP_IDLE;
					s_axis_tready <= 1'b1;
				end
				default: begin
					state_q <= LKUP_IDLE;
				end
			endcase
		end
	end

	// result datapath
	always_ff @(posedge axis_clk) begin
		if (state_q == LKUP_READ) begin
			entry_q <= rd_data;
		end
		if (data_pend_q) begin
			act_result.tag   <= queue_onehot(tag_ptr_q);
			act_result.entry <= entry_q;
		end
	end

endmodule

`default_nettype wire

/* parser_top.sv */
`timescale 1ns/1ps
`default_nettype none

module parser_top (
	input  wire                              axis_clk,
	input  wire                              aresetn,

	// packet input
	input  wire parser_pkg::axis_beat_t      s_axis,
	input  wire                              s_axis_tvalid,
	output logic                             s_axis_tready,

	// four packet queues share one data bus
	output parser_pkg::axis_beat_t           m_axis,
	output parser_pkg::queue_mask_t          m_axis_tvalid,
	input  wire parser_pkg::queue_mask_t     m_axis_tready,

	// vlan lookup
	input  wire parser_pkg::vlan_id_t        s_vlan_id,
	input  wire                              s_vlan_id_valid,
	output parser_pkg::action_result_t       act_result,
	output logic                             act_valid,

	// control stream
	input  wire parser_pkg::axis_beat_t      ctrl_s_axis,
	input  wire                              ctrl_s_axis_tvalid,
	output parser_pkg::axis_beat_t           ctrl_m_axis,
	output logic                             ctrl_m_axis_tvalid
);
	import parser_pkg::*;

	tbl_wr_t    tbl_wr;
	tbl_addr_t  rd_addr;
	act_entry_t rd_data;

	// ========================================================================
	// packet path
	// ========================================================================
	assign m_axis = s_axis;

	pkt_dispatch pkt_dispatch_i (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis.tlast),
		.m_axis_tready (m_axis_tready),
		.m_axis_tvalid (m_axis_tvalid)
	);

	// ========================================================================
	// control path and action table
	// ========================================================================
	ctrl_entry_writer ctrl_entry_writer_i (
		.axis_clk           (axis_clk),
		.aresetn            (aresetn),
		.ctrl_s_axis        (ctrl_s_axis),
		.ctrl_s_axis_tvalid (ctrl_s_axis_tvalid),
		.ctrl_m_axis        (ctrl_m_axis),
		.ctrl_m_axis_tvalid (ctrl_m_axis_tvalid),
		.tbl_wr             (tbl_wr)
	);

	parse_action_ram parse_action_ram_i (
		.axis_clk (axis_clk),
		.tbl_wr   (tbl_wr),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	// vlan-triggered read, also owns s_axis_tready
	action_lookup action_lookup_i (
		.axis_clk        (axis_clk),
		.aresetn         (aresetn),
		.s_vlan_id       (s_vlan_id),
		.s_vlan_id_valid (s_vlan_id_valid),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tlast    (s_axis.tlast),
		.rd_data         (rd_data),
		.rd_addr         (rd_addr),
		.s_axis_tready   (s_axis_tready),
		.act_result      (act_result),
		.act_valid       (act_valid)
	);

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input wire                             axis_clk,
	input wire                             aresetn,
	input wire parser_pkg::axis_beat_t     s_axis,
	input wire                             s_axis_tvalid,
	input wire                             s_axis_tready,
	input wire parser_pkg::axis_beat_t     m_axis,
	input wire parser_pkg::queue_mask_t    m_axis_tvalid,
	input wire parser_pkg::queue_mask_t    m_axis_tready,
	input wire                             s_vlan_id_valid,
	input wire parser_pkg::action_result_t act_result,
	input wire                             act_valid,
	input wire                             ctrl_s_axis_tvalid,
	input wire parser_pkg::axis_beat_t     ctrl_m_axis,
	input wire                             ctrl_m_axis_tvalid
);
	import parser_pkg::*;

	string          test_name;
	int             test_errors;
	int             error_count;
	int             tests_run;
	int             tests_failed;
	axis_beat_t     pkt_exp [$];
	queue_sel_t     qsel_exp [$];
	axis_beat_t     ctrl_exp [$];
	action_result_t act_exp [$];

	// accept history with bit 0 from the previous edge
	logic [2:0] accept_hist;
	logic       stall_prev;
	logic       ctrl_in_prev;

	task automatic pkt_beat_due(input queue_sel_t q, input axis_beat_t b);
		qsel_exp.push_back(q);
		pkt_exp.push_back(b);
	endtask

	task automatic ctrl_copy_due(input axis_beat_t b);
		ctrl_exp.push_back(b);
	endtask

	task automatic result_due(input action_result_t r);
		act_exp.push_back(r);
	endtask

	task automatic value_error(input string field, input string expv, input string actv);
		test_errors++;
		error_count++;
		$display("error %0s: %0s expected %0s actual %0s", test_name, field, expv, actv);
	endtask

	task automatic plain_error(input string what);
		test_errors++;
		error_count++;
		$display("test %0s went wrong: %0s", test_name, what);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		if (pkt_exp.size() != 0 || ctrl_exp.size() != 0 || act_exp.size() != 0) begin
			plain_error("some expected outputs never appeared");
		end
		pkt_exp.delete();
		qsel_exp.delete();
		ctrl_exp.delete();
		act_exp.delete();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %0s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic print_totals();
		$display("%0d tests, %0d ok, %0d with errors, %0d errors in all",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
	endtask

	initial begin
		test_name    = "reset";
		test_errors  = 0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
	end

	// ========================================================================
	// sampled at the rising edge where registered outputs hold the last value
	// ========================================================================
	always @(posedge axis_clk) begin
		logic           accept_now;
		queue_sel_t     q;
		axis_beat_t     b;
		action_result_t r;
		if (!aresetn) begin
			accept_hist  = '0;
			stall_prev   = 1'b0;
			ctrl_in_prev = 1'b0;
		end else begin
			// packet dispatch
			if (!s_axis_tvalid && m_axis_tvalid !== '0) begin
				plain_error("queue valid is high with no input beat");
			end
			if (s_axis_tvalid && !$onehot(m_axis_tvalid)) begin
				plain_error("queue valid is not one-hot");
			end
			if (s_axis_tvalid && (m_axis_tvalid & m_axis_tready) != '0) begin
				if (pkt_exp.size() == 0) begin
					plain_error("a beat moved to a queue with none expected");
				end else begin
					q = qsel_exp.pop_front();
					b = pkt_exp.pop_front();
					if (m_axis_tvalid !== queue_mask_t'(1 << q)) begin
						value_error("m_axis_tvalid", $sformatf("%b", queue_mask_t'(1 << q)),
							$sformatf("%b", m_axis_tvalid));
					end
					if (m_axis !== b) begin
						value_error("m_axis", $sformatf("%h", b), $sformatf("%h", m_axis));
					end
				end
			end

			// control pass-through
			if (ctrl_m_axis_tvalid) begin
				if (!ctrl_in_prev) begin
					plain_error("control output came without an input beat one cycle before");
				end
				if (ctrl_exp.size() == 0) begin
					plain_error("control output came with nothing expected");
				end else begin
					b = ctrl_exp.pop_front();
					if (ctrl_m_axis !== b) begin
						value_error("ctrl_m_axis", $sformatf("%h", b),
							$sformatf("%h", ctrl_m_axis));
					end
				end
			end
			ctrl_in_prev = ctrl_s_axis_tvalid;

			// a lookup is accepted unless the previous edge took one
			accept_now = s_vlan_id_valid && !accept_hist[0];
			if (s_axis_tready !== !stall_prev) begin
				value_error("s_axis_tready", $sformatf("%b", !stall_prev),
					$sformatf("%b", s_axis_tready));
			end
			if (act_valid !== accept_hist[2]) begin
				value_error("act_valid", $sformatf("%b", accept_hist[2]),
					$sformatf("%b", act_valid));
			end else if (act_valid) begin
				if (act_exp.size() == 0) begin
					plain_error("a lookup result came with nothing expected");
				end else begin
					r = act_exp.pop_front();
					if (act_result !== r) begin
						value_error("act_result", $sformatf("%h", r),
							$sformatf("%h", act_result));
					end
				end
			end
			stall_prev  = accept_now && s_axis_tvalid && s_axis.tlast;
			accept_hist = {accept_hist[1:0], accept_now};
		end
	end

endmodule

`default_nettype wire

/* tb_parser_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_parser_top;
	import parser_pkg::*;

	localparam int CLK_HALF    = 10;
	localparam int RST_CYCLES  = 4;
	localparam int CASE_CYCLES = 200;

	logic           axis_clk;
	logic           aresetn;
	axis_beat_t     s_axis;
	logic           s_axis_tvalid;
	logic           s_axis_tready;
	axis_beat_t     m_axis;
	queue_mask_t    m_axis_tvalid;
	queue_mask_t    m_axis_tready;
	vlan_id_t       s_vlan_id;
	logic           s_vlan_id_valid;
	action_result_t act_result;
	logic           act_valid;
	axis_beat_t     ctrl_s_axis;
	logic           ctrl_s_axis_tvalid;
	axis_beat_t     ctrl_m_axis;
	logic           ctrl_m_axis_tvalid;

	logic [15:0] lfsr;
	act_entry_t  tbl_model [TBL_DEPTH];
	int          pkt_no;
	int          result_no;
	int          case_count;
	string       case_kind [$];
	string       case_name [$];
	int          case_cnt [$];
	int          case_flag [$];

	parser_top dut_i (.*);

	tb_checker chk_i (.*);

	always #CLK_HALF axis_clk = ~axis_clk;

	// galois LFSR stepped once per bit
	function automatic logic lfsr_bit();
		logic lsb;
		lsb  = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb) begin
			lfsr = lfsr ^ 16'hb400;
		end
		return lsb;
	endfunction

	function automatic data_w_t rand_bits(input int n);
		data_w_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr_bit();
		end
		return v;
	endfunction

	function automatic axis_beat_t rand_beat(input logic last);
		axis_beat_t b;
		data_w_t    u;
		b.tdata = rand_bits(DATA_W);
		b.tkeep = '1;
		u       = rand_bits(TUSER_W);
		b.tuser = u[TUSER_W-1:0];
		b.tlast = last;
		return b;
	endfunction

	// byte 0 is shifted in first and ends up as the top entry byte
	function automatic act_entry_t reverse_bytes(input data_w_t d);
		act_entry_t e;
		e = '0;
		for (int i = 0; i < ENTRY_BYTES; i++) begin
			e = {e[ENTRY_W-9:0], d[i*8 +: 8]};
		end
		return e;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge axis_clk);
			s_axis_tvalid      = 1'b0;
			s_vlan_id_valid    = 1'b0;
			ctrl_s_axis_tvalid = 1'b0;
			m_axis_tready      = '1;
			@(posedge axis_clk);
		end
	endtask

	// the source holds off while s_axis_tready is low
	task automatic send_beat(input axis_beat_t b, input queue_sel_t q, input logic rand_ready);
		logic    done;
		data_w_t r;
		done = 1'b0;
		while (!done) begin
			@(negedge axis_clk);
			if (s_axis_tready) begin
				s_axis        = b;
				s_axis_tvalid = 1'b1;
				r             = rand_bits(NUM_QUEUES);
				m_axis_tready = rand_ready ? r[NUM_QUEUES-1:0] : '1;
				@(posedge axis_clk);
				done = m_axis_tready[q];
			end else begin
				s_axis_tvalid = 1'b0;
				@(posedge axis_clk);
			end
		end
	endtask

	task automatic send_packet(input logic rand_ready);
		int         len;
		queue_sel_t q;
		axis_beat_t b;
		data_w_t    r;
		r   = rand_bits(2);
		len = r[1:0] + 1;
		q   = queue_sel_t'(pkt_no % NUM_QUEUES);
		for (int i = 0; i < len; i++) begin
			b = rand_beat(i == len - 1);
			chk_i.pkt_beat_due(q, b);
			send_beat(b, q, rand_ready);
		end
		pkt_no++;
	endtask

	task automatic ctrl_beat(input axis_beat_t b);
		@(negedge axis_clk);
		ctrl_s_axis        = b;
		ctrl_s_axis_tvalid = 1'b1;
		@(posedge axis_clk);
	endtask

	task automatic pass_through_beats(input int count);
		axis_beat_t b;
		for (int i = 0; i < count; i++) begin
			b = rand_beat(lfsr_bit());
			if (i % 2 == 0) begin
				// flag never matches
				b.tdata[CTRL_FLAG_LSB +: 16] = 16'h1234;
			end else begin
				// write flag meant for another module id
				b.tdata[CTRL_FLAG_LSB +: 16] = CTRL_FLAG_WR;
				b.tdata[MOD_ID_LSB +: 3]     = 3'd5;
			end
			chk_i.ctrl_copy_due(b);
			ctrl_beat(b);
		end
	endtask

	task automatic write_table(input int count);
		axis_beat_t hdr;
		axis_beat_t b;
		data_w_t    r;
		tbl_addr_t  addr;
		hdr  = rand_beat(1'b0);
		r    = rand_bits(TBL_AW);
		addr = r[TBL_AW-1:0];
		hdr.tdata[MOD_ID_LSB +: 3]     = PARSER_MOD_ID;
		hdr.tdata[CTRL_FLAG_LSB +: 16] = CTRL_FLAG_WR;
		hdr.tdata[TBL_INDEX_LSB +: 8]  = {3'b000, addr};
		ctrl_beat(hdr);
		for (int i = 0; i < count; i++) begin
			b               = rand_beat(i == count - 1);
			tbl_model[addr] = reverse_bytes(b.tdata);
			addr            = addr + 1'b1;
			ctrl_beat(b);
		end
	endtask

	// modes are 0 spaced, 1 held for two cycles and 2 on a single-beat packet end
	task automatic lookup_burst(input int count, input int mode);
		data_w_t        r;
		vlan_id_t       id;
		action_result_t exp;
		axis_beat_t     b;
		for (int i = 0; i < count; i++) begin
			@(negedge axis_clk);
			r         = rand_bits(VLAN_W);
			id        = r[VLAN_W-1:0];
			exp.tag   = queue_mask_t'(1 << (result_no % NUM_QUEUES));
			exp.entry = tbl_model[id[VLAN_ADDR_LSB +: TBL_AW]];
			chk_i.result_due(exp);
			result_no++;
			s_vlan_id       = id;
			s_vlan_id_valid = 1'b1;
			if (mode == 2) begin
				b = rand_beat(1'b1);
				chk_i.pkt_beat_due(queue_sel_t'(pkt_no % NUM_QUEUES), b);
				pkt_no++;
				s_axis        = b;
				s_axis_tvalid = 1'b1;
				m_axis_tready = '1;
			end
			@(posedge axis_clk);
			@(negedge axis_clk);
			s_vlan_id_valid = (mode == 1);
			s_axis_tvalid   = 1'b0;
			@(posedge axis_clk);
		end
	endtask

	// ========================================================================
	// case file and main sequence
	// ========================================================================
	initial begin
		int    fd;
		string line;
		string kind;
		string name;
		int    cnt;
		int    flg;
		axis_clk           = 1'b0;
		aresetn            = 1'b0;
		s_axis             = '0;
		s_axis_tvalid      = 1'b0;
		m_axis_tready      = '1;
		s_vlan_id          = '0;
		s_vlan_id_valid    = 1'b0;
		ctrl_s_axis        = '0;
		ctrl_s_axis_tvalid = 1'b0;
		lfsr               = 16'd47440;
		pkt_no             = 0;
		result_no          = 0;
		case_count         = 0;

		fd = $fopen("parser_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file parser_cases.txt");
			$display("Testbench failed");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if ($sscanf(line, "%s %s %d %d", kind, name, cnt, flg) == 4) begin
					case_kind.push_back(kind);
					case_name.push_back(name);
					case_cnt.push_back(cnt);
					case_flag.push_back(flg);
				end
			end
			$fclose(fd);
			case_count = case_kind.size();

			repeat (RST_CYCLES) @(posedge axis_clk);
			@(negedge axis_clk);
			aresetn = 1'b1;

			for (int c = 0; c < case_count; c++) begin
				chk_i.start_test(case_name[c]);
				if (case_kind[c] == "PKT") begin
					for (int p = 0; p < case_cnt[c]; p++) begin
						send_packet(case_flag[c] != 0);
					end
				end else if (case_kind[c] == "CTRL") begin
					pass_through_beats(case_cnt[c]);
				end else if (case_kind[c] == "WRITE") begin
					write_table(case_cnt[c]);
				end else if (case_kind[c] == "LOOKUP") begin
					lookup_burst(case_cnt[c], case_flag[c]);
				end else begin
					chk_i.plain_error("unknown case kind in the case file");
				end
				idle_cycles(6);
				@(negedge axis_clk);
				chk_i.close_test();
			end

			chk_i.print_totals();
			if (chk_i.error_count == 0 && chk_i.tests_run > 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

	// run limit scales with the number of cases
	initial begin
		#1;
		#((case_count * CASE_CYCLES + RST_CYCLES) * 2 * CLK_HALF);
		$display("timeout, the cases did not finish in the time allowed");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* parser_cases.txt */
# kind name count flag
# flag: PKT nonzero = random queue ready, LOOKUP 0 = spaced, 1 = held, 2 = on packet end
PKT round_robin 6 0
PKT queue_backpressure 10 1
CTRL ctrl_pass_through 8 0
WRITE fill_table 32 0
LOOKUP spaced_lookups 8 0
LOOKUP held_valid 6 1
WRITE rewrite_part 5 0
LOOKUP after_rewrite 8 0
LOOKUP tlast_stall 4 2
PKT round_robin_again 5 1

/* compile.f */
parser_pkg.sv
pkt_dispatch.sv
ctrl_entry_writer.sv
parse_action_ram.sv
action_lookup.sv
parser_top.sv
tb_checker.sv
tb_parser_top.sv
